//--- tb.f
+incdir+test
logic/mvuPkg.sv
logic/weightMem.sv
logic/foldSequencer.sv
logic/mvuCore.sv
logic/mvuTop.sv
test/mvuTb.sv

//--- Makefile
SOURCES = logic/mvuPkg.sv logic/weightMem.sv logic/foldSequencer.sv logic/mvuCore.sv \
	logic/mvuTop.sv test/mvuTb.sv test/mvuCheck.svh

.PHONY: run clean

run: obj_dir/VmvuTb
	@out="$$(./obj_dir/VmvuTb)"; echo "$$out"; echo "$$out" | grep -qx '\*\* PASS \*\*'

obj_dir/VmvuTb: $(SOURCES) tb.f
	verilator --binary --timing --assert -Wno-fatal --top-module mvuTb -Mdir obj_dir -f tb.f

clean:
	rm -rf obj_dir

//--- test/mvuCheck.svh
`ifndef MVU_CHECK_SVH
`define MVU_CHECK_SVH

int errorCount = 0;	// Failed checks over the whole run
int checkCount = 0;	// Checks made over the whole run

// One PE result against the model
task automatic checkResult(input string what, input accuT expected, input accuT actual);
	checkCount++;
	if (actual !== expected) begin
		errorCount++;
		$display("mismatch %s %s: expected %0d, actual %0d", testName, what, expected, actual);
	end
endtask

// Distance from the final chunk strobe to pVld, in cycles
task automatic checkLatency(input int expected, input int actual);
	checkCount++;
	if (actual != expected) begin
		errorCount++;
		$display("mismatch %s latency: expected %0d, actual %0d", testName, expected, actual);
	end
endtask

// Failures with no value to compare
task automatic reportFailure(input string msg);
	errorCount++;
	$display("error in %s: %s", testName, msg);
endtask

`endif

//--- test/mvuTb.sv
`timescale 1ns/1ps

module mvuTb;
	import mvuPkg::*;

	localparam int unsigned Pe = 4;
	localparam int unsigned Simd = 4;
	localparam int unsigned MatrixWidth = 16;
	localparam int unsigned AccuWidth = 16;
	localparam int unsigned Folds = MatrixWidth / Simd;
	localparam int unsigned AddrWidth = Folds > 1 ? $clog2(Folds) : 1;
	localparam int Latency = 6;	// Final chunk strobe to pVld
	localparam int DrainLimit = Latency + 4;	// Wait for outstanding results
	localparam int MaxGap = 3;	// Idle cycles before a chunk in the gap test
	localparam int VecCount = 1 + 20 + 20 + 2 + 10 + 5;	// Full vectors over all tests
	localparam int ChunkCount = VecCount * Folds + 2;	// Plus the dropped partial vector
	localparam int LoadCycles = 4 * Folds;	// Four matrix loads
	localparam int GapCycles = 20 * Folds * MaxGap;	// Worst case of the gap test
	localparam int TimeoutCycles = 2 * (ChunkCount + LoadCycles + GapCycles) + 50;

	typedef logic signed [AccuWidth-1:0] accuT;	// One PE result

	string testName = "init";

	`include "mvuCheck.svh"

	logic clk;
	logic rst;
	logic wEn;
	logic [AddrWidth-1:0] wAddr;
	weightT [Pe-1:0][Simd-1:0] wData;
	logic aVld;
	actT [Simd-1:0] a;
	logic pVld;
	logic signed [Pe-1:0][AccuWidth-1:0] p;
	logic aFinal;	// Marks the final chunk of a vector

	weightT wMat [Pe][MatrixWidth];	// Model copy of the weight matrix
	actT vecBuf [MatrixWidth];	// Current input vector
	accuT expQ [$];	// Pe expected results per vector in order
	int finalCycle [$];	// Cycle of each final chunk strobe
	int cycle = 0;
	int seed;
	int errorsAtStart;
	int testsRun = 0;
	int testsFailed = 0;

	mvuTop #(
		.Pe(Pe), .Simd(Simd), .MatrixWidth(MatrixWidth),
		.AccuWidth(AccuWidth), .SignedActs(1'b0)
	) mvuTop_inst (
		.clk(clk), .rst(rst),
		.wEn(wEn), .wAddr(wAddr), .wData(wData),
		.aVld(aVld), .a(a),
		.pVld(pVld), .p(p)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;	// 100 ns period

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	initial begin
		wait (cycle >= TimeoutCycles);
		$display("timeout: run did not end within %0d cycles", TimeoutCycles);
		$display("** FAIL **");
		$finish;
	end

	// Pops Pe expected values per result and checks the strobe distance
	task automatic takeResult();
		accuT expected;
		if (expQ.size() < Pe) begin
			reportFailure("pVld rose with no vector pending");
		end else begin
			for (int i = 0; i < Pe; i++) begin
				expected = expQ.pop_front();
				checkResult($sformatf("p[%0d]", i), expected, p[i]);
			end
			if (finalCycle.size() == 0) begin
				reportFailure("pVld rose before the final chunk was strobed");
			end else begin
				checkLatency(Latency, cycle - finalCycle.pop_front());
			end
		end
	endtask

	// Outputs sampled mid-cycle away from the driving edge
	always @(negedge clk) begin
		if (aVld && aFinal) begin
			finalCycle.push_back(cycle);
		end
		if (pVld) begin
			takeResult();
		end
	end

	task automatic randomWeights();
		int r;
		for (int i = 0; i < Pe; i++) begin
			for (int c = 0; c < MatrixWidth; c++) begin
				r = $random(seed);
				wMat[i][c] = weightT'(r[3:0]);
			end
		end
	endtask

	task automatic constWeights(input weightT v);
		for (int i = 0; i < Pe; i++) begin
			for (int c = 0; c < MatrixWidth; c++) begin
				wMat[i][c] = v;
			end
		end
	endtask

	task automatic randomActs();
		int r;
		for (int c = 0; c < MatrixWidth; c++) begin
			r = $random(seed);
			vecBuf[c] = actT'(r[3:0]);
		end
	endtask

	// One fold row per cycle while streaming is idle
	task automatic loadWeights();
		weightT [Pe-1:0][Simd-1:0] row;
		for (int f = 0; f < int'(Folds); f++) begin
			for (int i = 0; i < Pe; i++) begin
				for (int j = 0; j < Simd; j++) begin
					row[i][j] = wMat[i][f * Simd + j];
				end
			end
			@(posedge clk);
			wEn <= 1'b1;
			wAddr <= AddrWidth'(f);
			wData <= row;
		end
		@(posedge clk);
		wEn <= 1'b0;
	endtask

	// Dot products of signed weights and unsigned activations wrapped to AccuWidth
	task automatic pushExpected();
		int sum;
		for (int i = 0; i < Pe; i++) begin
			sum = 0;
			for (int c = 0; c < MatrixWidth; c++) begin
				sum += int'(wMat[i][c]) * int'(vecBuf[c]);
			end
			expQ.push_back(accuT'(sum));
		end
	endtask

	// Drives the first chunks of vecBuf with 0 .. MaxGap idle cycles before each if asked
	task automatic driveVector(input int chunks, input bit useGaps);
		actT [Simd-1:0] chunk;
		int r;
		int gap;
		for (int f = 0; f < chunks; f++) begin
			r = $random(seed);
			gap = useGaps ? int'(r[1:0]) : 0;
			repeat (gap) begin
				@(posedge clk);
				aVld <= 1'b0;	// Bubble
				aFinal <= 1'b0;
			end
			for (int j = 0; j < Simd; j++) begin
				chunk[j] = vecBuf[f * Simd + j];
			end
			@(posedge clk);
			aVld <= 1'b1;
			a <= chunk;
			aFinal <= f == int'(Folds) - 1;
		end
	endtask

	task automatic sendVector(input bit useGaps);
		pushExpected();
		driveVector(Folds, useGaps);
	endtask

	task automatic idleInputs();
		@(posedge clk);
		aVld <= 1'b0;
		aFinal <= 1'b0;
	endtask

	// Waits for all pending results and then a short window for stray pulses
	task automatic drain();
		for (int k = 0; k < DrainLimit && expQ.size() != 0; k++) begin
			@(posedge clk);
		end
		if (expQ.size() != 0) begin
			reportFailure($sformatf("%0d results never appeared", expQ.size()));
			expQ.delete();
			finalCycle.delete();
		end
		repeat (2) @(posedge clk);
	endtask

	task automatic applyReset();
		@(posedge clk);
		rst <= 1'b1;
		aVld <= 1'b0;	// Drops the partial vector
		aFinal <= 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic beginTest(input string name);
		testName = name;
		errorsAtStart = errorCount;
	endtask

	task automatic endTest();
		testsRun++;
		if (errorCount == errorsAtStart) begin
			$display("test %s: ok", testName);
		end else begin
			testsFailed++;
			$display("test %s: failed with %0d errors", testName, errorCount - errorsAtStart);
		end
	endtask

	initial begin
		seed = 32'hffc4cf0b;
		rst = 1'b1;
		wEn = 1'b0;
		wAddr = '0;
		wData = '0;
		aVld = 1'b0;
		a = '0;
		aFinal = 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		randomWeights();
		loadWeights();

		beginTest("firstResult");
		repeat (3) @(posedge clk);	// Any pVld here has no pending vector
		randomActs();
		sendVector(1'b0);
		idleInputs();
		drain();
		endTest();

		beginTest("backToBack");
		for (int v = 0; v < 20; v++) begin
			randomActs();
			sendVector(1'b0);
		end
		idleInputs();
		drain();
		endTest();

		beginTest("randomGaps");
		for (int v = 0; v < 20; v++) begin
			randomActs();
			sendVector(1'b1);
		end
		idleInputs();
		drain();
		endTest();

		beginTest("extremes");
		constWeights(4'sh8);	// -8
		loadWeights();
		for (int c = 0; c < MatrixWidth; c++) begin
			vecBuf[c] = 4'hf;
		end
		sendVector(1'b0);
		idleInputs();
		constWeights(4'sh7);
		loadWeights();
		sendVector(1'b0);	// Same all-15 vector
		idleInputs();
		drain();
		endTest();

		beginTest("reload");
		for (int v = 0; v < 5; v++) begin
			randomActs();
			sendVector(1'b0);
		end
		idleInputs();
		randomWeights();
		loadWeights();	// Results of the new batch follow the new matrix
		for (int v = 0; v < 5; v++) begin
			randomActs();
			sendVector(1'b0);
		end
		idleInputs();
		drain();
		endTest();

		beginTest("midReset");
		randomActs();
		driveVector(2, 1'b0);	// Half a vector with no model entry
		applyReset();
		for (int v = 0; v < 5; v++) begin
			randomActs();
			sendVector(1'b0);
		end
		idleInputs();
		drain();
		endTest();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			testsRun, testsFailed, checkCount, errorCount);
		if (errorCount == 0 && testsFailed == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule : mvuTb

//--- logic/mvuTop.sv
`timescale 1ns/1ps

module mvuTop #(
	int unsigned Pe = 4,
	int unsigned Simd = 4,
	int unsigned MatrixWidth = 16,
	int unsigned AccuWidth = 16,
	bit SignedActs = 0,
	localparam int unsigned Folds = MatrixWidth / Simd,
	localparam int unsigned AddrWidth = Folds > 1 ? $clog2(Folds) : 1
) (
	input logic clk,
	input logic rst,
	input logic wEn,	// Weight load strobe
	input logic [AddrWidth-1:0] wAddr,	// Fold index of the loaded row
	input mvuPkg::weightT [Pe-1:0][Simd-1:0] wData,
	input logic aVld,	// Activation chunk strobe
	input mvuPkg::actT [Simd-1:0] a,
	output logic pVld,	// Six cycles after the final chunk
	output logic signed [Pe-1:0][AccuWidth-1:0] p
);
	import mvuPkg::*;

	// Folds must tile the matrix exactly
	if (MatrixWidth % Simd != 0) begin : genWidthCheck
		$error("mvuTop: MatrixWidth %0d is not a multiple of Simd %0d", MatrixWidth, Simd);
	end

	logic rdEn;
	logic [AddrWidth-1:0] rdAddr;
	weightT [Pe-1:0][Simd-1:0] foldW;	// Weight row of the current fold
	actT [Simd-1:0] foldA;	// Activations aligned to foldW
	coreCtlT ctl;

	foldSequencer #(.Simd(Simd), .MatrixWidth(MatrixWidth)) foldSequencer_inst (
		.clk(clk), .rst(rst),
		.aVld(aVld), .aIn(a),
		.rdEn(rdEn), .rdAddr(rdAddr),
		.aOut(foldA), .ctl(ctl)
	);

	weightMem #(.Pe(Pe), .Simd(Simd), .MatrixWidth(MatrixWidth)) weightMem_inst (
		.clk(clk), .rst(rst),
		.wEn(wEn), .wAddr(wAddr), .wData(wData),
		.rdEn(rdEn), .rdAddr(rdAddr),
		.w(foldW)
	);

	mvuCore #(.Pe(Pe), .Simd(Simd), .AccuWidth(AccuWidth), .SignedActs(SignedActs)) mvuCore_inst (
		.clk(clk), .rst(rst),
		.ctl(ctl), .w(foldW), .a(foldA),
		.vld(pVld), .p(p)
	);

endmodule : mvuTop

//--- logic/mvuCore.sv
`timescale 1ns/1ps

module mvuCore #(
	int unsigned Pe,
	int unsigned Simd,
	int unsigned AccuWidth,
	bit SignedActs
) (
	input logic clk,
	input logic rst,
	input mvuPkg::coreCtlT ctl,	// Last and zero flags of this fold
	input mvuPkg::weightT [Pe-1:0][Simd-1:0] w,	// Signed weights
	input mvuPkg::actT [Simd-1:0] a,	// Activations
	output logic vld,	// One pulse per completed vector
	output logic signed [Pe-1:0][AccuWidth-1:0] p
);
	import mvuPkg::*;

	localparam int unsigned TreeNodes = 2 * Simd - 1;	// Binary tree, leaves at the top

	// Last flag travels alongside the data, index is the stage number
	logic [1:5] lastPipe;

	always_ff @(posedge clk) begin
		if (rst) begin
			lastPipe <= '0;
		end else begin
			lastPipe <= {ctl.last, lastPipe[1:4]};
		end
	end

	assign vld = lastPipe[5];

	// Stage 1 input registers
	weightT [Pe-1:0][Simd-1:0] w1;
	actT [Simd-1:0] a1;

	always_ff @(posedge clk) begin
		w1 <= w;	// Product is zero anyway when a1 is cleared
	end

	always_ff @(posedge clk) begin
		if (rst || ctl.zero) begin
			a1 <= '0;	// Bubble adds nothing downstream
		end else begin
			a1 <= a;
		end
	end

	// Activation widened to a signed operand
	logic signed [NibbleWidth:0] aExt [Simd];

	always_comb begin
		for (int j = 0; j < Simd; j++) begin
			aExt[j] = $signed({SignedActs && a1[j][NibbleWidth-1], a1[j]});	// Zero or sign ext
		end
	end

	// Stage 2 products
	logic signed [ProdWidth-1:0] m2 [Pe][Simd];

	always_ff @(posedge clk) begin
		if (rst) begin
			m2 <= '{default: '0};
		end else begin
			for (int i = 0; i < Pe; i++) begin
				for (int j = 0; j < Simd; j++) begin
					m2[i][j] <= $signed(w1[i][j]) * aExt[j];
				end
			end
		end
	end

	// Adder tree per PE, node n sums children 2n+1 and 2n+2
	logic signed [AccuWidth-1:0] tree [Pe][TreeNodes];

	always_comb begin
		for (int i = 0; i < Pe; i++) begin
			for (int j = 0; j < Simd; j++) begin
				tree[i][Simd-1+j] = m2[i][j];	// Sign extended leaf
			end
			for (int n = int'(Simd) - 2; n >= 0; n--) begin
				tree[i][n] = tree[i][2*n+1] + tree[i][2*n+2];
			end
		end
	end

	// Stage 3 fold sums
	logic signed [AccuWidth-1:0] s3 [Pe];

	always_ff @(posedge clk) begin
		if (rst) begin
			s3 <= '{default: '0};
		end else begin
			for (int i = 0; i < Pe; i++) begin
				s3[i] <= tree[i][0];	// Root
			end
		end
	end

	// Stage 4 accumulators
	logic signed [AccuWidth-1:0] acc4 [Pe];

	always_ff @(posedge clk) begin
		if (rst) begin
			acc4 <= '{default: '0};
		end else begin
			for (int i = 0; i < Pe; i++) begin
				acc4[i] <= (lastPipe[4] ? '0 : acc4[i]) + s3[i];	// Restart after a last
			end
		end
	end

	// Stage 5 result register, captured on the closing fold only
	always_ff @(posedge clk) begin
		if (rst) begin
			p <= '0;
		end else if (lastPipe[4]) begin
			for (int i = 0; i < Pe; i++) begin
				p[i] <= acc4[i];	// Holds until the next vector
			end
		end
	end

	// A bubble flagged as last would emit a result for a vector never completed
	noLastOnBubble: assert property (
		@(posedge clk) disable iff (rst) !(ctl.last && ctl.zero)
	) else $error("mvuCore: last flag on a zero bubble");

endmodule : mvuCore

//--- logic/foldSequencer.sv
`timescale 1ns/1ps

module foldSequencer #(
	int unsigned Simd,
	int unsigned MatrixWidth,
	localparam int unsigned Folds = MatrixWidth / Simd,
	localparam int unsigned AddrWidth = Folds > 1 ? $clog2(Folds) : 1
) (
	input logic clk,
	input logic rst,
	input logic aVld,	// Chunk strobe
	input mvuPkg::actT [Simd-1:0] aIn,
	output logic rdEn,
	output logic [AddrWidth-1:0] rdAddr,
	output mvuPkg::actT [Simd-1:0] aOut,	// Chunk aligned with the weight read
	output mvuPkg::coreCtlT ctl
);
	import mvuPkg::*;

	localparam logic [AddrWidth-1:0] LastFold = AddrWidth'(Folds - 1);

	logic [AddrWidth-1:0] foldCnt;	// Chunks seen of the current vector
	logic foldLast;

	assign foldLast = foldCnt == LastFold;	// Current chunk closes the vector

	// Weight fetch runs in the strobe cycle itself
	assign rdEn = aVld;
	assign rdAddr = foldCnt;

	// Chunk counter, wraps at the fold count
	always_ff @(posedge clk) begin
		if (rst) begin
			foldCnt <= '0;	// Drops a partly received vector
		end else if (aVld) begin
			foldCnt <= foldLast ? '0 : foldCnt + 1'b1;
		end
	end

	// Activations ride one cycle behind to meet the registered memory output
	always_ff @(posedge clk) begin
		aOut <= aIn;
	end

	// Last/zero bundle, a missing strobe becomes a bubble
	always_ff @(posedge clk) begin
		if (rst) begin
			ctl <= CoreCtlIdle;
		end else begin
			ctl.last <= aVld && foldLast;
			ctl.zero <= !aVld;
		end
	end

	// Memory has only Folds rows, a stray address would read stale data
	foldInRange: assert property (
		@(posedge clk) disable iff (rst) rdAddr < Folds
	) else $error("foldSequencer: fold address %0d out of range", rdAddr);

endmodule : foldSequencer

//--- logic/weightMem.sv
`timescale 1ns/1ps

module weightMem #(
	int unsigned Pe,
	int unsigned Simd,
	int unsigned MatrixWidth,
	localparam int unsigned Folds = MatrixWidth / Simd,
	localparam int unsigned AddrWidth = Folds > 1 ? $clog2(Folds) : 1
) (
	input logic clk,
	input logic rst,
	input logic wEn,	// Load strobe, one fold row per cycle
	input logic [AddrWidth-1:0] wAddr,
	input mvuPkg::weightT [Pe-1:0][Simd-1:0] wData,
	input logic rdEn,	// Read strobe from the sequencer
	input logic [AddrWidth-1:0] rdAddr,
	output mvuPkg::weightT [Pe-1:0][Simd-1:0] w	// Fold row, one cycle after rdEn
);
	import mvuPkg::*;

	// All PE weights that belong to one fold
	typedef weightT [Pe-1:0][Simd-1:0] foldRowT;

	foldRowT mem [Folds];	// One fold row per address

	// Write port, visible to reads from the next cycle on
	always_ff @(posedge clk) begin
		if (wEn) begin
			mem[wAddr] <= wData;
		end
	end

	// Registered read port
	always_ff @(posedge clk) begin
		if (rdEn) begin
			w <= mem[rdAddr];	// Holds last row between reads
		end
	end

	// A reload while a vector streams would mix old and new matrix columns
	noLoadWhileStreaming: assert property (
		@(posedge clk) disable iff (rst) !(wEn && rdEn)
	) else $error("weightMem: weight load overlaps vector streaming");

endmodule : weightMem

//--- logic/mvuPkg.sv
package mvuPkg;

	localparam int unsigned NibbleWidth = 4;	// Operand width of the quantized datapath
	localparam int unsigned ProdWidth = 2 * NibbleWidth + 1;	// 4b signed x 5b signed product

	// Two's complement weight, -8 .. 7
	typedef logic signed [NibbleWidth-1:0] weightT;

	// Activation, 0 .. 15 unless the core runs in signed mode
	typedef logic [NibbleWidth-1:0] actT;

	// Per-cycle control handed from the sequencer to the core
	typedef struct packed {
		logic last;	// Final fold of the current vector
		logic zero;	// Bubble, product forced to zero
	} coreCtlT;

	// Control of a cycle without an activation chunk
	localparam coreCtlT CoreCtlIdle = '{last: 1'b0, zero: 1'b1};

endpackage : mvuPkg
